/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_cpu
FILELIST  = cpu.f

.PHONY: sim clean

# Build, run, and pass only if the pass line is printed
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q -F '*** PASSED ***'

clean:
	rm -rf obj_dir

/* core_defs.svh */
//**************************************
// Core constants: datapath widths and
// the fixed reset and trap addresses
//**************************************
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Widths fixed by RV32I
`define WORD_W 32   // Data and address width
`define REG_AW 5    // Register index width

// Fixed program counter values
`define RESET_PC 32'h0000_0000   // First fetch after reset
`define TRAP_PC  32'h0000_0100   // Invalid instruction handler

`endif

/* cpu.f */
+incdir+.
design/core_pkg.sv
design/regfile.sv
design/fetch.sv
design/decode.sv
design/hazard.sv
design/execute.sv
design/memory.sv
design/writeback.sv
design/cpu.sv
testbench/clock_gen.sv
testbench/tb_cpu.sv

/* design/core_pkg.sv */
//**************************************
// Core types shared by the pipeline
//**************************************
`include "core_defs.svh"

package core_pkg;

    //**************************************
    // Plain vectors
    //**************************************
    typedef logic [`WORD_W-1:0] word_t;      // Data or address
    typedef logic [31:0]        inst_t;      // Raw instruction word
    typedef logic [`REG_AW-1:0] reg_addr_t;  // Register index

    //**************************************
    // State and select encodings
    //**************************************
    typedef enum logic [2:0] {
        ALU_ADD,     // Also used for address calculation
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B   // LUI
    } alu_op_t;

    // Where a source operand comes from once the instruction reaches execute
    typedef enum logic [1:0] {
        FWD_RF,  // Register file value read in decode
        FWD_EX,  // Execute-to-memory register
        FWD_MM   // Memory-to-writeback register
    } fwd_sel_t;

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_WAIT_ACK,      // req high, waiting for ack
        MEM_WAIT_RELEASE   // req dropped, waiting for ack to fall
    } mem_state_t;

endpackage

/* design/cpu.sv */
//**************************************
// Five-stage RV32I subset core
//**************************************
`timescale 1ns/1ns

module cpu (
    input  logic            clk,
    input  logic            arst_n,
    input  core_pkg::inst_t imem_data,
    input  logic            dmem_ack,
    input  core_pkg::word_t dmem_rdata,
    output core_pkg::word_t imem_addr,
    output logic            dmem_req,
    output logic            dmem_we,
    output core_pkg::word_t dmem_addr,
    output core_pkg::word_t dmem_wdata,
    output core_pkg::word_t retired
);
    import core_pkg::*;

    //**************************************
    // Control between stages
    //**************************************
    logic      stall, mem_busy, branch, trap, flush;
    word_t     target;
    fwd_sel_t  rs1_sel, rs2_sel;

    // Fetch to decode
    logic      if_valid;
    word_t     if_pc;
    inst_t     if_inst;

    // Decode to execute
    logic      id_valid, id_rd_en, id_is_load, id_is_store;
    logic      id_is_branch, id_branch_ne, id_is_jal;
    alu_op_t   id_alu_op;
    word_t     id_a, id_b, id_store_data, id_imm, id_pc;
    reg_addr_t id_rd;

    // Execute to memory
    logic      ex_valid, ex_rd_en, ex_is_load, ex_is_store;
    word_t     ex_result, ex_store_data;
    reg_addr_t ex_rd;

    // Memory to writeback
    logic      mm_valid, mm_rd_en;
    word_t     mm_result;
    reg_addr_t mm_rd;

    // Register file ports
    reg_addr_t rs1_addr, rs2_addr, rd_addr;
    word_t     rs1_data, rs2_data, rd_data;
    logic      rd_en;

    fetch u_fetch (.*);

    decode u_decode (.*);   // Forwards ex_result and mm_result from the stage registers

    hazard u_hazard (.*);

    execute u_execute (.*);

    memory u_memory (.*);

    writeback u_writeback (.*);

    regfile u_regfile (
        .clk      (clk),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

/* design/decode.sv */
//**************************************
// Decode stage: field decode, immediates,
// operand select, decode-to-execute reg
//**************************************
`timescale 1ns/1ns

module decode (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  stall,
    input  logic                  mem_busy,
    input  logic                  flush,
    input  logic                  if_valid,
    input  core_pkg::word_t       if_pc,
    input  core_pkg::inst_t       if_inst,
    input  core_pkg::fwd_sel_t    rs1_sel,
    input  core_pkg::fwd_sel_t    rs2_sel,
    input  core_pkg::word_t       rs1_data,
    input  core_pkg::word_t       rs2_data,
    input  core_pkg::word_t       ex_result,
    input  core_pkg::word_t       mm_result,
    output core_pkg::reg_addr_t   rs1_addr,
    output core_pkg::reg_addr_t   rs2_addr,
    output logic                  trap,
    output logic                  id_valid,
    output core_pkg::alu_op_t     id_alu_op,
    output core_pkg::word_t       id_a,
    output core_pkg::word_t       id_b,
    output core_pkg::word_t       id_store_data,
    output core_pkg::reg_addr_t   id_rd,
    output logic                  id_rd_en,
    output logic                  id_is_load,
    output logic                  id_is_store,
    output logic                  id_is_branch,
    output logic                  id_branch_ne,
    output logic                  id_is_jal,
    output core_pkg::word_t       id_imm,
    output core_pkg::word_t       id_pc
);
    import core_pkg::*;

    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LUI = 7'b0110111;
    localparam logic [6:0] OP_LD  = 7'b0000011;
    localparam logic [6:0] OP_ST  = 7'b0100011;
    localparam logic [6:0] OP_BR  = 7'b1100011;
    localparam logic [6:0] OP_JAL = 7'b1101111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    alu_op_t    alu_op;
    word_t      imm;
    logic       use_rs1, use_rs2, b_imm, rd_en, invalid;
    logic       is_load, is_store, is_branch, is_jal;
    word_t      rs1_q, rs2_q, rs2_fwd;         // Register file values, late forwarded
    fwd_sel_t   rs1_sel_q, rs2_sel_q;
    logic       b_imm_q;

    assign opcode = if_inst[6:0];
    assign funct3 = if_inst[14:12];

    always_comb begin
        alu_op    = ALU_ADD;
        imm       = '0;
        {use_rs1, use_rs2, b_imm, rd_en, invalid} = '0;
        {is_load, is_store, is_branch, is_jal}    = '0;
        case (opcode)
            OP_REG: begin
                {use_rs1, use_rs2, rd_en} = 3'b111;
                case (funct3)
                    3'b000:  alu_op = if_inst[30] ? ALU_SUB : ALU_ADD;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: invalid = 1'b1;
                endcase
            end
            OP_IMM, OP_LD: begin   // ADDI and LW share the I format
                {use_rs1, b_imm, rd_en} = 3'b111;
                imm     = {{20{if_inst[31]}}, if_inst[31:20]};
                is_load = (opcode == OP_LD);
                invalid = (funct3 != (is_load ? 3'b010 : 3'b000));
            end
            OP_LUI: begin
                {b_imm, rd_en} = 2'b11;
                alu_op = ALU_PASS_B;
                imm    = {if_inst[31:12], 12'b0};
            end
            OP_ST: begin
                {use_rs1, use_rs2, b_imm, is_store} = 4'b1111;
                imm     = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
                invalid = (funct3 != 3'b010);
            end
            OP_BR: begin
                {use_rs1, use_rs2, is_branch} = 3'b111;
                imm = {{19{if_inst[31]}}, if_inst[31], if_inst[7], if_inst[30:25],
                       if_inst[11:8], 1'b0};
                invalid = (funct3[2:1] != 2'b00);   // BEQ and BNE only
            end
            OP_JAL: begin
                {is_jal, rd_en} = 2'b11;
                imm = {{11{if_inst[31]}}, if_inst[31], if_inst[19:12], if_inst[20],
                       if_inst[30:21], 1'b0};
            end
            default: invalid = 1'b1;
        endcase
    end

    // Unused sources read as x0 so they never match a producer
    assign rs1_addr = use_rs1 ? if_inst[19:15] : '0;
    assign rs2_addr = use_rs2 ? if_inst[24:20] : '0;
    assign trap     = if_valid && invalid && !flush;   // Wrong path never traps

    //**************************************
    // Decode-to-execute register
    //**************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_valid <= 1'b0;
        end else if (!mem_busy) begin
            id_valid <= if_valid && !stall && !flush && !invalid;   // Bubble otherwise
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_busy) begin
            id_alu_op    <= alu_op;
            id_imm       <= imm;
            id_pc        <= if_pc;
            id_rd        <= if_inst[11:7];
            id_rd_en     <= rd_en;
            id_is_load   <= is_load;
            id_is_store  <= is_store;
            id_is_branch <= is_branch;
            id_branch_ne <= funct3[0];
            id_is_jal    <= is_jal;
            rs1_q        <= rs1_data;
            rs2_q        <= rs2_data;
            rs1_sel_q    <= rs1_sel;
            rs2_sel_q    <= rs2_sel;
            b_imm_q      <= b_imm;
        end
    end

    // Producers have moved one stage on by the time the operand is used
    assign id_a = (rs1_sel_q == FWD_EX) ? ex_result :
                  (rs1_sel_q == FWD_MM) ? mm_result : rs1_q;
    assign rs2_fwd = (rs2_sel_q == FWD_EX) ? ex_result :
                     (rs2_sel_q == FWD_MM) ? mm_result : rs2_q;
    assign id_b          = b_imm_q ? id_imm : rs2_fwd;
    assign id_store_data = rs2_fwd;

    // An invalid word is dropped from fetch on the next edge
    a_trap_drop : assert property (@(posedge clk) disable iff (!arst_n)
        trap && !mem_busy |-> if_valid ##1 !if_valid);

endmodule

/* design/execute.sv */
//**************************************
// Execute stage: ALU, branch resolve,
// execute-to-memory register
//**************************************
`timescale 1ns/1ns

module execute (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                mem_busy,
    input  logic                id_valid,
    input  core_pkg::alu_op_t   id_alu_op,
    input  core_pkg::word_t     id_a,
    input  core_pkg::word_t     id_b,
    input  core_pkg::word_t     id_store_data,
    input  core_pkg::reg_addr_t id_rd,
    input  logic                id_rd_en,
    input  logic                id_is_load,
    input  logic                id_is_store,
    input  logic                id_is_branch,
    input  logic                id_branch_ne,
    input  logic                id_is_jal,
    input  core_pkg::word_t     id_imm,
    input  core_pkg::word_t     id_pc,
    output logic                branch,
    output core_pkg::word_t     target,
    output logic                flush,
    output logic                ex_valid,
    output core_pkg::word_t     ex_result,
    output core_pkg::word_t     ex_store_data,
    output core_pkg::reg_addr_t ex_rd,
    output logic                ex_rd_en,
    output logic                ex_is_load,
    output logic                ex_is_store
);
    import core_pkg::*;

    word_t alu;

    always_comb begin
        case (id_alu_op)
            ALU_SUB:    alu = id_a - id_b;
            ALU_AND:    alu = id_a & id_b;
            ALU_OR:     alu = id_a | id_b;
            ALU_XOR:    alu = id_a ^ id_b;
            ALU_PASS_B: alu = id_b;
            default:    alu = id_a + id_b;   // ADD, ADDI, load and store address
        endcase
    end

    // BEQ/BNE compare, JAL always taken
    assign branch = id_valid && (id_is_jal || (id_is_branch && ((id_a == id_b) ^ id_branch_ne)));
    assign target = id_pc + id_imm;
    assign flush  = branch;   // Kills fetch and decode registers

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
        end else if (!mem_busy) begin
            ex_valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_busy) begin
            ex_result     <= id_is_jal ? id_pc + 32'd4 : alu;   // Link value
            ex_store_data <= id_store_data;
            ex_rd         <= id_rd;
            ex_rd_en      <= id_rd_en;
            ex_is_load    <= id_is_load;
            ex_is_store   <= id_is_store;
        end
    end

endmodule

/* design/fetch.sv */
//**************************************
// Fetch stage: PC, code port and the
// fetch-to-decode register
//**************************************
`timescale 1ns/1ns
`include "core_defs.svh"

module fetch (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            stall,       // Load-use hold
    input  logic            mem_busy,    // Whole pipeline frozen
    input  logic            branch,      // Taken branch or jump in execute
    input  core_pkg::word_t target,
    input  logic            trap,        // Invalid instruction in decode
    input  logic            flush,
    input  core_pkg::inst_t imem_data,
    output core_pkg::word_t imem_addr,
    output logic            if_valid,
    output core_pkg::word_t if_pc,
    output core_pkg::inst_t if_inst
);
    import core_pkg::*;

    word_t pc;

    assign imem_addr = pc;   // Code memory answers in the same cycle

    // Next PC, branch wins over trap
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= `RESET_PC;
            if_valid <= 1'b0;
        end else if (!mem_busy) begin
            if (branch) begin
                pc <= target;
            end else if (trap) begin
                pc <= `TRAP_PC;
            end else if (!stall) begin
                pc <= pc + 32'd4;
            end
            if (flush || trap) begin
                if_valid <= 1'b0;   // Drop wrong-path or invalid word
            end else if (!stall) begin
                if_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_busy && !stall) begin
            if_pc   <= pc;
            if_inst <= imem_data;
        end
    end

    // Decode suppresses trap behind a taken branch
    a_branch_trap : assert property (@(posedge clk) disable iff (!arst_n)
        !(branch && trap));

endmodule

/* design/hazard.sv */
//**************************************
// Load-use stall and forwarding selects
//**************************************
`timescale 1ns/1ns

module hazard (
    input  core_pkg::reg_addr_t rs1_addr,
    input  core_pkg::reg_addr_t rs2_addr,
    input  logic                if_valid,
    input  logic                id_valid,    // Instruction in execute
    input  core_pkg::reg_addr_t id_rd,
    input  logic                id_rd_en,
    input  logic                id_is_load,
    input  logic                ex_valid,    // Instruction in memory
    input  core_pkg::reg_addr_t ex_rd,
    input  logic                ex_rd_en,
    output logic                stall,
    output core_pkg::fwd_sel_t  rs1_sel,
    output core_pkg::fwd_sel_t  rs2_sel
);
    import core_pkg::*;

    logic id_wr, ex_wr;   // Stage will write a nonzero register

    assign id_wr = id_valid && id_rd_en && (id_rd != '0);
    assign ex_wr = ex_valid && ex_rd_en && (ex_rd != '0);

    // Load result is not ready until it leaves memory
    assign stall = if_valid && id_wr && id_is_load &&
                   ((id_rd == rs1_addr) || (id_rd == rs2_addr));

    // Youngest producer first, register file covers writeback
    always_comb begin
        rs1_sel = FWD_RF;
        rs2_sel = FWD_RF;
        if (id_wr && id_rd == rs1_addr) begin
            rs1_sel = FWD_EX;
        end else if (ex_wr && ex_rd == rs1_addr) begin
            rs1_sel = FWD_MM;
        end
        if (id_wr && id_rd == rs2_addr) begin
            rs2_sel = FWD_EX;
        end else if (ex_wr && ex_rd == rs2_addr) begin
            rs2_sel = FWD_MM;
        end
    end

endmodule

/* design/memory.sv */
//**************************************
// Memory stage: four-phase data master,
// memory-to-writeback register
//**************************************
`timescale 1ns/1ns

module memory (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                ex_valid,
    input  core_pkg::word_t     ex_result,
    input  core_pkg::word_t     ex_store_data,
    input  core_pkg::reg_addr_t ex_rd,
    input  logic                ex_rd_en,
    input  logic                ex_is_load,
    input  logic                ex_is_store,
    input  logic                dmem_ack,
    input  core_pkg::word_t     dmem_rdata,
    output logic                mem_busy,
    output logic                dmem_req,
    output logic                dmem_we,
    output core_pkg::word_t     dmem_addr,
    output core_pkg::word_t     dmem_wdata,
    output logic                mm_valid,
    output core_pkg::word_t     mm_result,
    output core_pkg::reg_addr_t mm_rd,
    output logic                mm_rd_en
);
    import core_pkg::*;

    mem_state_t state;
    word_t      rdata_q;   // Load data taken at ack
    logic       mem_op;

    assign mem_op   = ex_valid && (ex_is_load || ex_is_store);
    // Access is done in the cycle where ack has fallen
    assign mem_busy = mem_op && !(state == MEM_WAIT_RELEASE && !dmem_ack);

    //**************************************
    // Handshake FSM
    //**************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= MEM_IDLE;
            dmem_req <= 1'b0;
            dmem_we  <= 1'b0;
        end else begin
            case (state)
                MEM_IDLE: if (mem_op) begin
                    dmem_req <= 1'b1;
                    dmem_we  <= ex_is_store;
                    state    <= MEM_WAIT_ACK;
                end
                MEM_WAIT_ACK: if (dmem_ack) begin
                    dmem_req <= 1'b0;
                    state    <= MEM_WAIT_RELEASE;
                end
                default: if (!dmem_ack) begin
                    dmem_we <= 1'b0;
                    state   <= MEM_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == MEM_IDLE) begin
            dmem_addr  <= ex_result;        // Held stable for the whole access
            dmem_wdata <= ex_store_data;
        end
        if (state == MEM_WAIT_ACK && dmem_ack) begin
            rdata_q <= dmem_rdata;
        end
    end

    //**************************************
    // Memory-to-writeback register
    //**************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mm_valid <= 1'b0;
        end else begin
            mm_valid <= ex_valid && !mem_busy;   // Bubble while the access runs
        end
    end

    // Payload held while stalled so decode can still forward from it
    always_ff @(posedge clk) begin
        if (!mem_busy) begin
            mm_result <= ex_is_load ? rdata_q : ex_result;
            mm_rd     <= ex_rd;
            mm_rd_en  <= ex_rd_en;
        end
    end

    // Request only rises from an edge where ack was seen low
    a_req_ack : assert property (@(posedge clk) disable iff (!arst_n)
        $rose(dmem_req) |-> !$past(dmem_ack));

endmodule

/* design/regfile.sv */
//**************************************
// Register file, 2 read and 1 write port
//**************************************
`timescale 1ns/1ns
`include "core_defs.svh"

module regfile (
    input  logic               clk,
    input  logic [`REG_AW-1:0] rs1_addr,
    input  logic [`REG_AW-1:0] rs2_addr,
    input  logic               rd_en,
    input  logic [`REG_AW-1:0] rd_addr,
    input  logic [`WORD_W-1:0] rd_data,
    output logic [`WORD_W-1:0] rs1_data,
    output logic [`WORD_W-1:0] rs2_data
);
    logic [`WORD_W-1:0] regs [2**`REG_AW];   // Architectural registers x0 to x31

    always_ff @(posedge clk) begin
        if (rd_en) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // x0 reads as zero and a same-cycle write is seen at once
    assign rs1_data = (rs1_addr == '0) ? '0 :
                      (rd_en && rd_addr == rs1_addr) ? rd_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 :
                      (rd_en && rd_addr == rs2_addr) ? rd_data : regs[rs2_addr];

endmodule

/* design/writeback.sv */
//**************************************
// Writeback: register write, retire count
//**************************************
`timescale 1ns/1ns

module writeback (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                mm_valid,
    input  core_pkg::word_t     mm_result,
    input  core_pkg::reg_addr_t mm_rd,
    input  logic                mm_rd_en,
    output logic                rd_en,
    output core_pkg::reg_addr_t rd_addr,
    output core_pkg::word_t     rd_data,
    output core_pkg::word_t     retired
);
    import core_pkg::*;

    word_t count;   // Stores count too, they arrive with rd_en low

    assign rd_en   = mm_valid && mm_rd_en;
    assign rd_addr = mm_rd;
    assign rd_data = mm_result;
    assign retired = count;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (mm_valid) begin
            count <= count + 32'd1;
        end
    end

endmodule

/* testbench/clock_gen.sv */
//**************************************
// Testbench clock and reset source
//**************************************
`timescale 1ns/1ns

module clock_gen (
    output logic clk,
    output logic arst_n
);
    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;               // Held for 5 rising edges
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
    end

endmodule

/* testbench/tb_cpu.sv */
//**************************************
// Testbench for cpu: program ROM, data
// memory responder, store table checks
//**************************************
`timescale 1ns/1ns

module tb_cpu;
    import core_pkg::*;

    localparam int N_ROWS        = 9;
    localparam int EXP_RETIRED   = 24;             // Instructions retired before the halt
    localparam int STORE_TIMEOUT = 400;            // Cycles
    localparam int REQ_TIMEOUT   = 50;
    localparam logic [31:0] HALT_ADDR = 32'hffff_fff0;   // Never acked so the core freezes

    // Expected stores in program order
    logic [31:0] exp_addr [N_ROWS] = '{32'h40, 32'h44, 32'h48, 32'h4c, 32'h50,
                                       32'h54, 32'h60, 32'h6c, 32'h74};
    logic [31:0] exp_data [N_ROWS] = '{32'h1234_5768, 32'h1234_5678, 32'h1234_5668,
                                       32'h1234_56f8, 32'h0000_0080, 32'h0000_1324,
                                       32'h0000_00f0, 32'h0000_0058, 32'h0000_0bad};

    logic        clk, arst_n;
    inst_t       imem_data;
    word_t       imem_addr, dmem_addr, dmem_wdata, dmem_rdata, retired;
    logic        dmem_req, dmem_we, dmem_ack;
    logic [31:0] rom [128];
    logic [31:0] dmem [256];
    logic [31:0] addr_q [$];                        // Stores seen at ack rise
    logic [31:0] data_q [$];
    logic        halt_seen = 1'b0;
    int          errors = 0;
    int          resp_errors = 0;
    int          checks = 0;

    clock_gen u_clk (.clk(clk), .arst_n(arst_n));

    cpu dut (.*);

    assign imem_data = rom[imem_addr[8:2]];   // Combinational code port

    //****************************************
    // Instruction encoders
    //****************************************
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] store_word(input logic [11:0] imm,
                                               input logic [4:0] rs2,
                                               input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jump_link(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic load_program();
        for (int i = 0; i < 128; i++) begin
            rom[i] = 32'h0000_0013;                              // NOP
        end
        rom[0]  = {20'h12345, 5'd1, 7'b0110111};                 // lui  x1
        rom[1]  = i_type(12'h678, 5'd1, 3'b000, 5'd1, 7'b0010011); // addi x1, x1
        rom[2]  = i_type(12'h0f0, 5'd0, 3'b000, 5'd2, 7'b0010011); // addi x2, x0
        rom[3]  = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);         // add  x3 = x1 + x2
        rom[4]  = r_type(7'h20, 5'd2, 5'd3, 3'b000, 5'd4);         // sub  x4 = x3 - x2
        rom[5]  = r_type(7'h00, 5'd3, 5'd4, 3'b111, 5'd5);         // and  x5 = x4 & x3
        rom[6]  = r_type(7'h00, 5'd2, 5'd5, 3'b110, 5'd6);         // or   x6 = x5 | x2
        rom[7]  = r_type(7'h00, 5'd1, 5'd6, 3'b100, 5'd7);         // xor  x7 = x6 ^ x1
        rom[8]  = store_word(12'h040, 5'd3, 5'd0);
        rom[9]  = store_word(12'h044, 5'd4, 5'd0);
        rom[10] = store_word(12'h048, 5'd5, 5'd0);
        rom[11] = store_word(12'h04c, 5'd6, 5'd0);
        rom[12] = store_word(12'h050, 5'd7, 5'd0);
        rom[13] = i_type(12'h080, 5'd0, 3'b010, 5'd8, 7'b0000011); // lw x8, then use at once
        rom[14] = r_type(7'h00, 5'd2, 5'd8, 3'b000, 5'd9);
        rom[15] = store_word(12'h054, 5'd9, 5'd0);
        rom[16] = b_type(13'd12, 5'd1, 5'd4, 3'b000);            // beq taken to 0x4c
        rom[17] = store_word(12'h058, 5'd0, 5'd0);               // Skipped
        rom[18] = store_word(12'h05c, 5'd0, 5'd0);               // Skipped
        rom[19] = b_type(13'd8, 5'd2, 5'd2, 3'b001);             // bne not taken
        rom[20] = store_word(12'h060, 5'd2, 5'd0);
        rom[21] = jump_link(21'd12, 5'd10);                      // Link 0x58
        rom[22] = store_word(12'h064, 5'd0, 5'd0);               // Skipped
        rom[23] = store_word(12'h068, 5'd0, 5'd0);               // Skipped
        rom[24] = store_word(12'h06c, 5'd10, 5'd0);
        rom[25] = 32'hffff_ffff;                                 // Undefined opcode
        rom[26] = store_word(12'h070, 5'd0, 5'd0);               // Never reached
        // Trap handler at 0x100
        rom[64] = {20'h00001, 5'd11, 7'b0110111};
        rom[65] = i_type(12'hbad, 5'd11, 3'b000, 5'd11, 7'b0010011); // 0x1000 - 0x453
        rom[66] = store_word(12'h074, 5'd11, 5'd0);
        rom[67] = i_type(12'hff0, 5'd0, 3'b010, 5'd0, 7'b0000011);  // Halt load
        rom[68] = jump_link(21'd0, 5'd0);
    endtask

    //****************************************
    // Data memory responder, four-phase
    //****************************************
    initial begin : responder
        int unsigned delay;
        int          guard;
        logic [7:0]  idx;
        void'($urandom(32'h39f5));                    // Seeds the ack delays
        dmem_ack   = 1'b0;
        dmem_rdata = '0;
        for (int i = 0; i < 256; i++) begin
            idx     = i[7:0];
            dmem[i] = {8'hc3, idx, ~idx, idx ^ 8'h5a};
        end
        dmem[8'h20] = 32'h0000_1234;                  // Load source at 0x80
        forever begin
            @(posedge clk);
            #1;
            if (arst_n && dmem_req && !dmem_ack) begin
                if (dmem_addr == HALT_ADDR) begin
                    halt_seen = 1'b1;
                end else begin
                    delay = $urandom_range(5, 0);
                    repeat (delay) begin
                        @(posedge clk);
                        #1;
                    end
                    dmem_ack = 1'b1;
                    if (dmem_we) begin
                        dmem[dmem_addr[9:2]] = dmem_wdata;
                        addr_q.push_back(dmem_addr);   // Sampled at ack rise
                        data_q.push_back(dmem_wdata);
                    end else begin
                        dmem_rdata = dmem[dmem_addr[9:2]];
                    end
                    guard = 0;
                    while (dmem_req && guard < REQ_TIMEOUT) begin
                        @(posedge clk);
                        #1;
                        guard++;
                    end
                    if (dmem_req) begin
                        $display("Data request was not dropped after ack at %0t", $time);
                        resp_errors++;
                    end
                    delay = $urandom_range(3, 0);
                    repeat (delay) begin
                        @(posedge clk);
                        #1;
                    end
                    dmem_ack = 1'b0;
                end
            end
        end
    end

    //****************************************
    // Main sequence
    //****************************************
    initial begin : main
        int          guard;
        logic [31:0] got_addr, got_data;
        load_program();
        guard = 0;
        while (!arst_n && guard < 20) begin
            @(negedge clk);
            guard++;
        end
        if (!arst_n) begin
            $display("Timed out waiting for reset to be released");
            errors++;
        end
        for (int i = 0; i < N_ROWS; i++) begin
            guard = 0;
            while (addr_q.size() == 0 && guard < STORE_TIMEOUT) begin
                @(negedge clk);
                guard++;
            end
            if (addr_q.size() == 0) begin
                $display("Timed out waiting for store row %0d at %0t", i, $time);
                errors++;
                break;
            end
            got_addr = addr_q.pop_front();
            got_data = data_q.pop_front();
            checks++;
            assert (got_addr == exp_addr[i]) else begin
                $display("[ERROR] %0t dmem_addr: expected %h, got %h",
                         $time, exp_addr[i], got_addr);
                errors++;
            end
            assert (got_data == exp_data[i]) else begin
                $display("[ERROR] %0t dmem_wdata: expected %h, got %h",
                         $time, exp_data[i], got_data);
                errors++;
            end
        end
        // Halt load freezes the pipeline, so retired settles
        guard = 0;
        while (!halt_seen && guard < STORE_TIMEOUT) begin
            @(negedge clk);
            guard++;
        end
        if (!halt_seen) begin
            $display("Timed out waiting for the core to reach the halt load");
            errors++;
        end
        guard = 0;
        while (retired != EXP_RETIRED && guard < 20) begin
            @(negedge clk);
            guard++;
        end
        repeat (8) @(negedge clk);              // Must not move any further
        checks++;
        assert (retired == EXP_RETIRED) else begin
            $display("[ERROR] %0t retired: expected %0d, got %0d", $time, EXP_RETIRED, retired);
            errors++;
        end
        assert (addr_q.size() == 0) else begin
            $display("Unexpected extra stores were seen: %0d", addr_q.size());
            errors++;
        end
        $display("Checks: %0d, errors: %0d", checks, errors + resp_errors);
        if (errors + resp_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
